// ==== include/mm_accel_consts.svh ====
/*
 * matrix-multiply accelerator constants
 * matrix size, element / accumulator / address widths, buffer depth
 */

`ifndef MM_ACCEL_CONSTS_SVH
`define MM_ACCEL_CONSTS_SVH

// square matrix dimension
`define MAT_N 4

// signed input element
`define ELEM_W 8

// result element, also the memory data width
`define ACC_W 32

// byte address on the memory bus
`define ADDR_W 32

// row address inside a tile buffer
`define ROW_AW 2

// rows held per tile buffer
`define BUF_DEPTH `MAT_N

// flat index into the result matrix
`define C_IDX_W 4

`endif

// ==== source/mm_accel_pkg.sv ====
/*
 * matrix-multiply accelerator types
 * element, row and result types plus the DMA and engine state encodings
 */

`default_nettype none

`include "mm_accel_consts.svh"

package mm_accel_pkg;

    // one signed matrix element
    typedef logic signed [`ELEM_W-1:0] elem_t;

    // element k sits in byte k, so a row is one memory word
    typedef elem_t [`MAT_N-1:0] row_t;

    // signed result element
    typedef logic signed [`ACC_W-1:0] acc_t;

    // dma sequencer states
    typedef enum logic [2:0] {
        DMA_IDLE,
        DMA_LOAD_ADDR,
        DMA_LOAD_DATA,
        DMA_RUN_MM,
        DMA_STORE_ADDR,
        DMA_STORE_RESP,
        DMA_FINISH
    } dma_state_e;

    // multiply engine states
    typedef enum logic [1:0] {
        MM_IDLE,
        MM_FETCH,
        MM_ACCUM
    } mm_state_e;

endpackage

`default_nettype wire

// ==== source/axi_mem_if.sv ====
/*
 * reduced single-beat AXI memory port
 * AR/R for reads, AW/W/B for writes, valid/ready on each channel
 */

`timescale 1ns/1ps
`default_nettype none

`include "mm_accel_consts.svh"

interface axi_mem_if import mm_accel_pkg::*; ();

    // read address
    logic               arvalid;
    logic [`ADDR_W-1:0] araddr;
    logic               arready;

    // read data, one matrix row per beat
    logic               rvalid;
    row_t               rdata;
    logic               rready;

    // write address
    logic               awvalid;
    logic [`ADDR_W-1:0] awaddr;
    logic               awready;

    // write data, one result element per beat
    logic               wvalid;
    acc_t               wdata;
    logic               wready;

    // write response, resp field not carried
    logic               bvalid;
    logic               bready;

    modport master (
        output arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, bready,
        input  arready, rvalid, rdata, awready, wready, bvalid
    );

    modport slave (
        input  arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, bready,
        output arready, rvalid, rdata, awready, wready, bvalid
    );

endinterface

`default_nettype wire

// ==== source/tile_buffer.sv ====
/*
 * tile buffer, one matrix tile stored row by row
 * one write port, one read port with a registered read
 */

`timescale 1ns/1ps
`default_nettype none

`include "mm_accel_consts.svh"

module tile_buffer import mm_accel_pkg::*; (
    input  logic               clk,
    input  logic               we_i,
    input  logic [`ROW_AW-1:0] waddr_i,
    input  row_t               wdata_i,
    input  logic [`ROW_AW-1:0] raddr_i,
    output row_t               rdata_o
);

    row_t mem_q [`BUF_DEPTH];

    // write at the clock edge
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk) begin
        rdata_o <= mem_q[raddr_i];
    end

endmodule

`default_nettype wire

// ==== source/mm_engine.sv ====
/*
 * four-lane signed multiply-accumulate engine
 * walks i and k, adds A[i][k] * B[k][j] into row i of C for all j at once
 */

`timescale 1ns/1ps
`default_nettype none

`include "mm_accel_consts.svh"

module mm_engine import mm_accel_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    output logic                done_o,
    output logic [`ROW_AW-1:0]  a_raddr_o,
    output logic [`ROW_AW-1:0]  b_raddr_o,
    input  row_t                a_row_i,
    input  row_t                b_row_i,
    input  logic [`C_IDX_W-1:0] c_idx_i,
    output acc_t                c_data_o
);

    mm_state_e               state_q;
    logic [2*`ROW_AW-1:0]    step_q;
    logic [2*`ROW_AW-1:0]    acc_step_q;
    logic                    done_q;
    logic [`ROW_AW-1:0]      acc_i;
    logic [`ROW_AW-1:0]      acc_k;
    elem_t                   a_elem;
    elem_t                   b_elem [`MAT_N];
    acc_t                    prod [`MAT_N];
    acc_t                    c_q [`MAT_N][`MAT_N];

    // step is {i, k}, addresses go out one cycle ahead of the data
    assign a_raddr_o = step_q[2*`ROW_AW-1:`ROW_AW];
    assign b_raddr_o = step_q[`ROW_AW-1:0];

    // indices of the rows now on the buffer outputs
    assign acc_i = acc_step_q[2*`ROW_AW-1:`ROW_AW];
    assign acc_k = acc_step_q[`ROW_AW-1:0];

    // four signed 8x8 lanes, sign-extended before the multiply
    always_comb begin
        a_elem = a_row_i[acc_k];
        for (int j = 0; j < `MAT_N; j++) begin
            b_elem[j] = b_row_i[j];
            prod[j]   = acc_t'(a_elem) * acc_t'(b_elem[j]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= MM_IDLE;
            step_q     <= '0;
            acc_step_q <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                MM_IDLE: begin
                    if (start_i) begin
                        step_q  <= '0;
                        state_q <= MM_FETCH;
                    end
                end
                MM_FETCH: begin
                    // covers the buffer read latency
                    step_q     <= step_q + 1'b1;
                    acc_step_q <= step_q;
                    state_q    <= MM_ACCUM;
                end
                MM_ACCUM: begin
                    step_q     <= step_q + 1'b1;
                    acc_step_q <= step_q;
                    if (&acc_step_q) begin
                        done_q  <= 1'b1;
                        state_q <= MM_IDLE;
                    end
                end
                default: begin
                    state_q <= MM_IDLE;
                end
            endcase
        end
    end

    // result array, cleared by start and kept until the next one
    always_ff @(posedge clk) begin
        if (state_q == MM_IDLE && start_i) begin
            for (int i = 0; i < `MAT_N; i++) begin
                for (int j = 0; j < `MAT_N; j++) begin
                    c_q[i][j] <= '0;
                end
            end
        end else if (state_q == MM_ACCUM) begin
            for (int j = 0; j < `MAT_N; j++) begin
                c_q[acc_i][j] <= c_q[acc_i][j] + prod[j];
            end
        end
    end

    assign done_o   = done_q;
    assign c_data_o = c_q[c_idx_i[`C_IDX_W-1:`C_IDX_W/2]][c_idx_i[`C_IDX_W/2-1:0]];

endmodule

`default_nettype wire

// ==== source/dma_engine.sv ====
/*
 * DMA sequencer for the matrix-multiply accelerator
 * loads A and B rows into the tile buffers, runs the multiply engine,
 * then stores the result matrix one word per AXI write
 */

`timescale 1ns/1ps
`default_nettype none

`include "mm_accel_consts.svh"

module dma_engine import mm_accel_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`ADDR_W-1:0]  mat_a_addr_i,
    input  logic [`ADDR_W-1:0]  mat_b_addr_i,
    input  logic [`ADDR_W-1:0]  mat_c_addr_i,
    input  logic                start_i,
    output logic                done_o,
    axi_mem_if.master           mem,
    output logic                buf_a_we_o,
    output logic                buf_b_we_o,
    output logic [`ROW_AW-1:0]  buf_waddr_o,
    output row_t                buf_wdata_o,
    output logic                mm_start_o,
    input  logic                mm_done_i,
    output logic [`C_IDX_W-1:0] c_idx_o,
    input  acc_t                c_data_i
);

    localparam int LOAD_CW = $clog2(2 * `MAT_N);
    localparam int STORE_CW = `C_IDX_W;
    localparam logic [LOAD_CW-1:0] LOAD_LAST = LOAD_CW'(2 * `MAT_N - 1);
    localparam logic [STORE_CW-1:0] STORE_LAST = STORE_CW'(`MAT_N * `MAT_N - 1);

    dma_state_e          state_q;
    logic [LOAD_CW-1:0]  load_cnt_q;
    logic [STORE_CW-1:0] store_cnt_q;
    logic                aw_done_q;
    logic                w_done_q;
    logic                mm_start_q;
    logic [`ADDR_W-1:0]  a_base_q;
    logic [`ADDR_W-1:0]  b_base_q;
    logic [`ADDR_W-1:0]  c_base_q;
    logic [`ROW_AW-1:0]  load_row;
    logic                load_is_b;
    logic [`ADDR_W-1:0]  load_off;
    logic [`ADDR_W-1:0]  store_off;
    logic                ar_fire;
    logic                r_fire;
    logic                aw_fire;
    logic                w_fire;
    logic                b_fire;
    logic                aw_ok;
    logic                w_ok;

    // load order A0 B0 A1 B1 ..., low bit picks the matrix
    assign load_is_b = load_cnt_q[0];
    assign load_row  = load_cnt_q[LOAD_CW-1:1];
    assign load_off  = {{(`ADDR_W - `ROW_AW - 2){1'b0}}, load_row, 2'b00};
    assign store_off = {{(`ADDR_W - STORE_CW - 2){1'b0}}, store_cnt_q, 2'b00};

    // channel valids follow the state, payloads only move on a handshake
    assign mem.arvalid = (state_q == DMA_LOAD_ADDR);
    assign mem.araddr  = (load_is_b ? b_base_q : a_base_q) + load_off;
    assign mem.rready  = (state_q == DMA_LOAD_DATA);
    assign mem.awvalid = (state_q == DMA_STORE_ADDR) && !aw_done_q;
    assign mem.awaddr  = c_base_q + store_off;
    assign mem.wvalid  = (state_q == DMA_STORE_ADDR) && !w_done_q;
    assign mem.wdata   = c_data_i;
    assign mem.bready  = (state_q == DMA_STORE_RESP);

    assign ar_fire = mem.arvalid && mem.arready;
    assign r_fire  = mem.rready && mem.rvalid;
    assign aw_fire = mem.awvalid && mem.awready;
    assign w_fire  = mem.wvalid && mem.wready;
    assign b_fire  = mem.bready && mem.bvalid;

    // AW and W may finish in either order
    assign aw_ok = aw_done_q || aw_fire;
    assign w_ok  = w_done_q || w_fire;

    // row lands in its buffer on the R handshake itself
    assign buf_a_we_o  = r_fire && !load_is_b;
    assign buf_b_we_o  = r_fire && load_is_b;
    assign buf_waddr_o = load_row;
    assign buf_wdata_o = mem.rdata;

    assign mm_start_o = mm_start_q;
    assign c_idx_o    = store_cnt_q;
    assign done_o     = (state_q == DMA_FINISH);

    // base addresses, captured on an accepted start
    always_ff @(posedge clk) begin
        if (state_q == DMA_IDLE && start_i) begin
            a_base_q <= mat_a_addr_i;
            b_base_q <= mat_b_addr_i;
            c_base_q <= mat_c_addr_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= DMA_IDLE;
            load_cnt_q  <= '0;
            store_cnt_q <= '0;
            aw_done_q   <= 1'b0;
            w_done_q    <= 1'b0;
            mm_start_q  <= 1'b0;
        end else begin
            mm_start_q <= 1'b0;
            case (state_q)
                DMA_IDLE: begin
                    // start is ignored anywhere else
                    if (start_i) begin
                        load_cnt_q  <= '0;
                        store_cnt_q <= '0;
                        state_q     <= DMA_LOAD_ADDR;
                    end
                end
                DMA_LOAD_ADDR: begin
                    if (ar_fire) begin
                        state_q <= DMA_LOAD_DATA;
                    end
                end
                DMA_LOAD_DATA: begin
                    if (r_fire) begin
                        load_cnt_q <= load_cnt_q + 1'b1;
                        if (load_cnt_q == LOAD_LAST) begin
                            // both tiles complete, kick the engine
                            mm_start_q <= 1'b1;
                            state_q    <= DMA_RUN_MM;
                        end else begin
                            state_q <= DMA_LOAD_ADDR;
                        end
                    end
                end
                DMA_RUN_MM: begin
                    if (mm_done_i) begin
                        state_q <= DMA_STORE_ADDR;
                    end
                end
                DMA_STORE_ADDR: begin
                    if (aw_ok && w_ok) begin
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                        state_q   <= DMA_STORE_RESP;
                    end else begin
                        aw_done_q <= aw_ok;
                        w_done_q  <= w_ok;
                    end
                end
                DMA_STORE_RESP: begin
                    // next write only after this response
                    if (b_fire) begin
                        store_cnt_q <= store_cnt_q + 1'b1;
                        if (store_cnt_q == STORE_LAST) begin
                            state_q <= DMA_FINISH;
                        end else begin
                            state_q <= DMA_STORE_ADDR;
                        end
                    end
                end
                DMA_FINISH: begin
                    state_q <= DMA_IDLE;
                end
                default: begin
                    state_q <= DMA_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/mm_accel_top.sv ====
/*
 * matrix-multiply accelerator top level
 * DMA, two tile buffers and the MAC engine, AXI memory port as plain ports
 */

`timescale 1ns/1ps
`default_nettype none

`include "mm_accel_consts.svh"

module mm_accel_top import mm_accel_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`ADDR_W-1:0] mat_a_addr_i,
    input  logic [`ADDR_W-1:0] mat_b_addr_i,
    input  logic [`ADDR_W-1:0] mat_c_addr_i,
    input  logic               start_i,
    output logic               done_o,
    output logic               m_arvalid_o,
    output logic [`ADDR_W-1:0] m_araddr_o,
    input  logic               m_arready_i,
    input  logic               m_rvalid_i,
    input  logic [`ACC_W-1:0]  m_rdata_i,
    output logic               m_rready_o,
    output logic               m_awvalid_o,
    output logic [`ADDR_W-1:0] m_awaddr_o,
    input  logic               m_awready_i,
    output logic               m_wvalid_o,
    output logic [`ACC_W-1:0]  m_wdata_o,
    input  logic               m_wready_i,
    input  logic               m_bvalid_i,
    output logic               m_bready_o
);

    logic                buf_a_we;
    logic                buf_b_we;
    logic [`ROW_AW-1:0]  buf_waddr;
    row_t                buf_wdata;
    logic                mm_start;
    logic                mm_done;
    logic [`ROW_AW-1:0]  a_raddr;
    logic [`ROW_AW-1:0]  b_raddr;
    row_t                a_row;
    row_t                b_row;
    logic [`C_IDX_W-1:0] c_idx;
    acc_t                c_data;

    axi_mem_if mem ();

    // memory side of the bundle onto the plain ports
    assign m_arvalid_o = mem.arvalid;
    assign m_araddr_o  = mem.araddr;
    assign mem.arready = m_arready_i;
    assign mem.rvalid  = m_rvalid_i;
    assign mem.rdata   = m_rdata_i;
    assign m_rready_o  = mem.rready;
    assign m_awvalid_o = mem.awvalid;
    assign m_awaddr_o  = mem.awaddr;
    assign mem.awready = m_awready_i;
    assign m_wvalid_o  = mem.wvalid;
    assign m_wdata_o   = mem.wdata;
    assign mem.wready  = m_wready_i;
    assign mem.bvalid  = m_bvalid_i;
    assign m_bready_o  = mem.bready;

    dma_engine dma_engine_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .mem          (mem.master),
        .buf_a_we_o   (buf_a_we),
        .buf_b_we_o   (buf_b_we),
        .buf_waddr_o  (buf_waddr),
        .buf_wdata_o  (buf_wdata),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .c_idx_o      (c_idx),
        .c_data_i     (c_data)
    );

    // A tile
    tile_buffer buf_a (
        .clk     (clk),
        .we_i    (buf_a_we),
        .waddr_i (buf_waddr),
        .wdata_i (buf_wdata),
        .raddr_i (a_raddr),
        .rdata_o (a_row)
    );

    // B tile
    tile_buffer buf_b (
        .clk     (clk),
        .we_i    (buf_b_we),
        .waddr_i (buf_waddr),
        .wdata_i (buf_wdata),
        .raddr_i (b_raddr),
        .rdata_o (b_row)
    );

    mm_engine mm_engine_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (mm_start),
        .done_o    (mm_done),
        .a_raddr_o (a_raddr),
        .b_raddr_o (b_raddr),
        .a_row_i   (a_row),
        .b_row_i   (b_row),
        .c_idx_i   (c_idx),
        .c_data_o  (c_data)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clkgen.sv ====
/*
 * testbench clock and reset source
 * free-running clock, active-low reset held for a few cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        // release on the inactive edge
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/mm_accel_chk.sv ====
/*
 * protocol checker for the matrix-multiply accelerator
 * reset quiet state, AXI valid/payload stability, one transfer in flight,
 * single-cycle done pulse
 */

`timescale 1ns/1ps
`default_nettype none

`include "mm_accel_consts.svh"

module mm_accel_chk (
    input logic               clk,
    input logic               rst_n,
    input logic               done_i,
    input logic               arvalid_i,
    input logic [`ADDR_W-1:0] araddr_i,
    input logic               arready_i,
    input logic               rvalid_i,
    input logic               rready_i,
    input logic               awvalid_i,
    input logic [`ADDR_W-1:0] awaddr_i,
    input logic               awready_i,
    input logic               wvalid_i,
    input logic [`ACC_W-1:0]  wdata_i,
    input logic               wready_i,
    input logic               bvalid_i,
    input logic               bready_i
);

    int   fail_cnt = 0;
    logic rd_pend_q;
    logic wr_pend_q;
    logic quiet;

    assign quiet = !(arvalid_i || rready_i || awvalid_i || wvalid_i || bready_i || done_i);

    // read open from AR handshake to R handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend_q <= 1'b0;
        end else if (arvalid_i && arready_i) begin
            rd_pend_q <= 1'b1;
        end else if (rvalid_i && rready_i) begin
            rd_pend_q <= 1'b0;
        end
    end

    // write open from AW handshake to B handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pend_q <= 1'b0;
        end else if (awvalid_i && awready_i) begin
            wr_pend_q <= 1'b1;
        end else if (bvalid_i && bready_i) begin
            wr_pend_q <= 1'b0;
        end
    end

    // in reset and the first cycle out of it
    reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> quiet)
        else begin $error("bus outputs or done active around reset"); fail_cnt++; end

    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
        else begin $error("AR dropped or changed before handshake"); fail_cnt++; end

    aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
        else begin $error("AW dropped or changed before handshake"); fail_cnt++; end

    w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
        else begin $error("W dropped or changed before handshake"); fail_cnt++; end

    one_read: assert property (@(posedge clk) disable iff (!rst_n) rd_pend_q |-> !arvalid_i)
        else begin $error("second read issued while one is open"); fail_cnt++; end

    one_write: assert property (@(posedge clk) disable iff (!rst_n) wr_pend_q |-> !awvalid_i)
        else begin $error("second write issued while one is open"); fail_cnt++; end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done_i |=> !done_i)
        else begin $error("done held longer than one cycle"); fail_cnt++; end

endmodule

bind mm_accel_top mm_accel_chk chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .done_i    (done_o),
    .arvalid_i (m_arvalid_o),
    .araddr_i  (m_araddr_o),
    .arready_i (m_arready_i),
    .rvalid_i  (m_rvalid_i),
    .rready_i  (m_rready_o),
    .awvalid_i (m_awvalid_o),
    .awaddr_i  (m_awaddr_o),
    .awready_i (m_awready_i),
    .wvalid_i  (m_wvalid_o),
    .wdata_i   (m_wdata_o),
    .wready_i  (m_wready_i),
    .bvalid_i  (m_bvalid_i),
    .bready_i  (m_bready_o)
);

`default_nettype wire

// ==== sim/mm_accel_tb.sv ====
/*
 * testbench for the matrix-multiply accelerator
 * AXI memory model with random ready/valid delays, six multiply runs,
 * product, address and busy-start checks, watchdog
 */

`timescale 1ns/1ps
`default_nettype none

`include "mm_accel_consts.svh"

module mm_accel_tb;

    localparam logic [31:0] SEED = 32'h71fa33c0;
    localparam int MEM_WORDS = 64;
    localparam int A_WORD    = 4;
    localparam int B_WORD    = 16;

    // 8 row reads plus 16 result writes per run at worst case cycles per transfer
    localparam int RUNS     = 6;
    localparam int XFERS    = 2 * `MAT_N + `MAT_N * `MAT_N;
    localparam int XFER_CYC = 12;
    localparam int RUN_OVH  = 60;
    localparam int WDOG_CYC = RUNS * (XFERS * XFER_CYC + RUN_OVH) + 200;

    logic               clk;
    logic               rst_n;
    logic [`ADDR_W-1:0] mat_a_addr_i;
    logic [`ADDR_W-1:0] mat_b_addr_i;
    logic [`ADDR_W-1:0] mat_c_addr_i;
    logic               start_i;
    logic               done_o;
    logic               m_arvalid_o;
    logic [`ADDR_W-1:0] m_araddr_o;
    logic               m_arready_i;
    logic               m_rvalid_i;
    logic [`ACC_W-1:0]  m_rdata_i;
    logic               m_rready_o;
    logic               m_awvalid_o;
    logic [`ADDR_W-1:0] m_awaddr_o;
    logic               m_awready_i;
    logic               m_wvalid_o;
    logic [`ACC_W-1:0]  m_wdata_o;
    logic               m_wready_i;
    logic               m_bvalid_i;
    logic               m_bready_o;

    // memory image and access bookkeeping
    logic [31:0] mem_q [MEM_WORDS];
    logic [31:0] shadow_q [MEM_WORDS];
    int          rd_cnt [MEM_WORDS];
    int          wr_cnt [MEM_WORDS];
    int          rd_base [MEM_WORDS];
    int          wr_base [MEM_WORDS];
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [31:0] a_rows [`MAT_N];
    logic [31:0] b_rows [`MAT_N];
    int          done_cnt;
    int          errors;
    int          chk_fails;

    tb_clkgen #(.PERIOD_NS(20), .RST_CYCLES(3)) clkgen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mm_accel_top mm_accel_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .m_arvalid_o  (m_arvalid_o),
        .m_araddr_o   (m_araddr_o),
        .m_arready_i  (m_arready_i),
        .m_rvalid_i   (m_rvalid_i),
        .m_rdata_i    (m_rdata_i),
        .m_rready_o   (m_rready_o),
        .m_awvalid_o  (m_awvalid_o),
        .m_awaddr_o   (m_awaddr_o),
        .m_awready_i  (m_awready_i),
        .m_wvalid_o   (m_wvalid_o),
        .m_wdata_o    (m_wdata_o),
        .m_wready_i   (m_wready_i),
        .m_bvalid_i   (m_bvalid_i),
        .m_bready_o   (m_bready_o)
    );

    // background for words outside A and B that differs for every address
    function automatic logic [31:0] fill_word(input int w);
        return (32'(w) * 32'h9e3779b1) ^ 32'h5a5ac3c3;
    endfunction

    function automatic logic addr_ok(input logic [31:0] addr);
        return (addr < 32'(4 * MEM_WORDS)) && (addr[1:0] == 2'b00);
    endfunction

    // byte k of a row as a signed element
    function automatic int elem_of(input logic [31:0] row, input int k);
        logic signed [7:0] e;
        e = row[8*k +: 8];
        return int'(e);
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp) else begin
            errors++;
            $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    // AR then R with one read at a time
    task automatic serve_reads();
        int unsigned delay;
        logic [31:0] addr;
        forever begin
            @(negedge clk);
            if (rst_n && m_arvalid_o) begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge clk);
                addr = m_araddr_o;
                m_arready_i = 1'b1;
                @(negedge clk);
                m_arready_i = 1'b0;
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge clk);
                m_rdata_i = 32'h0;
                assert (addr_ok(addr)) else begin
                    errors++;
                    $display("read at %08h falls outside the memory model", addr);
                end
                if (addr_ok(addr)) begin
                    m_rdata_i = mem_q[addr >> 2];
                    rd_cnt[addr >> 2]++;
                end
                m_rvalid_i = 1'b1;
                while (!m_rready_o) @(negedge clk);
                @(negedge clk);
                m_rvalid_i = 1'b0;
            end
        end
    endtask

    // AW and W accepted independently before B
    task automatic serve_writes();
        int unsigned aw_delay;
        int unsigned w_delay;
        int unsigned b_delay;
        forever begin
            @(negedge clk);
            if (rst_n && m_awvalid_o) begin
                aw_delay = $urandom_range(3, 0);
                w_delay  = $urandom_range(3, 0);
                b_delay  = $urandom_range(3, 0);
                fork
                    begin
                        repeat (aw_delay) @(negedge clk);
                        wr_addr = m_awaddr_o;
                        m_awready_i = 1'b1;
                        @(negedge clk);
                        m_awready_i = 1'b0;
                    end
                    begin
                        repeat (w_delay) @(negedge clk);
                        wr_data = m_wdata_o;
                        m_wready_i = 1'b1;
                        @(negedge clk);
                        m_wready_i = 1'b0;
                    end
                join
                repeat (b_delay) @(negedge clk);
                assert (addr_ok(wr_addr)) else begin
                    errors++;
                    $display("write at %08h falls outside the memory model", wr_addr);
                end
                if (addr_ok(wr_addr)) begin
                    mem_q[wr_addr >> 2] = wr_data;
                    wr_cnt[wr_addr >> 2]++;
                end
                m_bvalid_i = 1'b1;
                while (!m_bready_o) @(negedge clk);
                @(negedge clk);
                m_bvalid_i = 1'b0;
            end
        end
    endtask

    task automatic count_done();
        forever begin
            @(negedge clk);
            if (rst_n && done_o) begin
                done_cnt++;
            end
        end
    endtask

    // one accepted start and one ignored start while busy before all checks
    task automatic run_case(input string name, input int c_word);
        int busy_wait;
        int exp_val;
        int exp_cnt;
        int done_base;
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem_q[w] = fill_word(w);
        end
        for (int r = 0; r < `MAT_N; r++) begin
            mem_q[A_WORD + r] = a_rows[r];
            mem_q[B_WORD + r] = b_rows[r];
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            shadow_q[w] = mem_q[w];
            rd_base[w]  = rd_cnt[w];
            wr_base[w]  = wr_cnt[w];
        end
        done_base = done_cnt;
        mat_a_addr_i = 32'(4 * A_WORD);
        mat_b_addr_i = 32'(4 * B_WORD);
        mat_c_addr_i = 32'(4 * c_word);
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        // junk config so only the captured bases give the right addresses
        mat_a_addr_i = 32'h0000_1000;
        mat_b_addr_i = 32'h0000_2000;
        mat_c_addr_i = 32'h0000_3000;
        busy_wait = int'($urandom_range(20, 4));
        repeat (busy_wait) @(negedge clk);
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        while (done_cnt == done_base) @(negedge clk);
        // settle time where a wrongly accepted start would show up
        repeat (12) @(negedge clk);
        for (int i = 0; i < `MAT_N; i++) begin
            for (int j = 0; j < `MAT_N; j++) begin
                exp_val = 0;
                for (int k = 0; k < `MAT_N; k++) begin
                    exp_val += elem_of(a_rows[i], k) * elem_of(b_rows[k], j);
                end
                check_word($sformatf("%s C[%0d][%0d]", name, i, j), 32'(exp_val),
                    mem_q[c_word + i * `MAT_N + j]);
            end
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            exp_cnt = ((w >= A_WORD && w < A_WORD + `MAT_N) ||
                       (w >= B_WORD && w < B_WORD + `MAT_N)) ? 1 : 0;
            check_word($sformatf("%s reads of word %0d", name, w), 32'(exp_cnt),
                32'(rd_cnt[w] - rd_base[w]));
            exp_cnt = (w >= c_word && w < c_word + `MAT_N * `MAT_N) ? 1 : 0;
            check_word($sformatf("%s writes to word %0d", name, w), 32'(exp_cnt),
                32'(wr_cnt[w] - wr_base[w]));
            if (exp_cnt == 0) begin
                check_word($sformatf("%s untouched word %0d", name, w), shadow_q[w], mem_q[w]);
            end
        end
        check_word($sformatf("%s done pulses", name), 32'd1, 32'(done_cnt - done_base));
    endtask

    initial begin : main
        void'($urandom(SEED));
        mat_a_addr_i = '0;
        mat_b_addr_i = '0;
        mat_c_addr_i = '0;
        start_i      = 1'b0;
        m_arready_i  = 1'b0;
        m_rvalid_i   = 1'b0;
        m_rdata_i    = '0;
        m_awready_i  = 1'b0;
        m_wready_i   = 1'b0;
        m_bvalid_i   = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        done_cnt     = 0;
        errors       = 0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            rd_cnt[w] = 0;
            wr_cnt[w] = 0;
        end
        fork
            serve_reads();
            serve_writes();
            count_done();
        join_none
        wait (rst_n);
        @(negedge clk);
        // random matrices with the C base alternating between two regions
        for (int r = 0; r < 4; r++) begin
            for (int row = 0; row < `MAT_N; row++) begin
                a_rows[row] = $urandom();
                b_rows[row] = $urandom();
            end
            run_case($sformatf("product run %0d", r), (r % 2 == 0) ? 32 : 48);
        end
        for (int row = 0; row < `MAT_N; row++) begin
            a_rows[row] = 32'h80808080;
            b_rows[row] = 32'h80808080;
        end
        run_case("all -128", 32);
        // rows of C come out near -65024 and +65026
        for (int row = 0; row < `MAT_N; row++) begin
            a_rows[row] = (row % 2 == 0) ? 32'h7f807f80 : 32'h807f807f;
            b_rows[row] = (row % 2 == 0) ? 32'h7f7f7f7f : 32'h80808080;
        end
        run_case("mixed 127 -128", 48);
        chk_fails = mm_accel_top_i.chk_i.fail_cnt;
        $display("value errors: %0d, assertion failures: %0d", errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WDOG_CYC) @(posedge clk);
        $display("timeout: the runs did not finish within %0d cycles", WDOG_CYC);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
source/mm_accel_pkg.sv
source/axi_mem_if.sv
source/tile_buffer.sv
source/mm_engine.sv
source/dma_engine.sv
source/mm_accel_top.sv
sim/tb_clkgen.sv
sim/mm_accel_chk.sv
sim/mm_accel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the accelerator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mm_accel_tb -f files.f -o mm_accel_sim

./obj_dir/mm_accel_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
else
    exit 1
fi
